// File: design/divCluster_defines.svh
`ifndef DIVCLUSTER_DEFINES_SVH
`define DIVCLUSTER_DEFINES_SVH

// parallel divide units in the cluster
`define DIV_UNITS 4

// operand and result width
`define DIV_XLEN 32

// sequence number width
`define DIV_SQN_W 6

`endif

// File: design/divPkg.sv
package divPkg;

    // codes 3 to 7 are illegal
    typedef enum logic [2:0] {
        DIVU = 3'd0,
        REMU = 3'd1,
        SQRT = 3'd2
    } divOp_t;

    typedef enum logic [1:0] {
        NONE     = 2'd0,
        DIV_ZERO = 2'd1,
        ILLEGAL  = 2'd2
    } divFlags_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        DONE = 2'd2
    } unitState_t;

endpackage

// File: design/divIssue.sv
`timescale 1ns/1ps
`include "divCluster_defines.svh"

module divIssue (
    input  logic                     clk,
    input  logic                     rst,

    // wishbone classic slave, write only
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  divPkg::divOp_t           datOp,
    input  logic [`DIV_XLEN-1:0]     datA,
    input  logic [`DIV_XLEN-1:0]     datB,
    input  logic [`DIV_SQN_W-1:0]    datSqN,
    output logic                     ack,

    input  logic                     flushValid,
    input  logic [`DIV_SQN_W-1:0]    flushSqN,

    // shared issue lines to the units
    input  logic [`DIV_UNITS-1:0]    idle,
    output logic [`DIV_UNITS-1:0]    start,
    output divPkg::divOp_t           op,
    output logic [`DIV_XLEN-1:0]     srcA,
    output logic [`DIV_XLEN-1:0]     srcB,
    output logic [`DIV_SQN_W-1:0]    sqN
);

    logic                    accept;
    logic [`DIV_UNITS-1:0]   pick;
    logic [`DIV_SQN_W-1:0]   sqDiff;
    logic                    dropOp;

    // no second accept while ack is still up
    assign accept = cyc && stb && !ack && |idle;
    assign pick   = idle & (~idle + 1'b1);   // lowest idle unit

    // op younger than a flush in the accept cycle
    assign sqDiff = datSqN - flushSqN;
    assign dropOp = flushValid && ($signed(sqDiff) > 0);

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            start <= '0;
        end else begin
            ack <= accept;
            if (accept && we && !dropOp) begin
                start <= pick;
            end else begin
                start <= '0;
            end
        end
    end

    // issue payload, valid alongside start
    always_ff @(posedge clk) begin
        if (accept) begin
            op   <= datOp;
            srcA <= datA;
            srcB <= datB;
            sqN  <= datSqN;
        end
    end

endmodule

// File: design/divSqrtUnit.sv
`timescale 1ns/1ps
`include "divCluster_defines.svh"

module divSqrtUnit (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     start,
    input  divPkg::divOp_t           op,
    input  logic [`DIV_XLEN-1:0]     srcA,
    input  logic [`DIV_XLEN-1:0]     srcB,
    input  logic [`DIV_SQN_W-1:0]    sqN,

    input  logic                     flushValid,
    input  logic [`DIV_SQN_W-1:0]    flushSqN,

    input  logic                     taken,
    output logic                     idle,
    output logic                     done,
    output logic [`DIV_XLEN-1:0]     result,
    output divPkg::divFlags_t        flags,
    output logic [`DIV_SQN_W-1:0]    resSqN
);

    localparam int remWidth = `DIV_XLEN + 2;
    localparam int cntWidth = $clog2(`DIV_XLEN);

    divPkg::unitState_t      state;
    divPkg::divOp_t          opReg;
    logic [`DIV_XLEN-1:0]    divisor;
    logic [`DIV_XLEN-1:0]    acc;        // dividend or radicand, msb first
    logic [`DIV_XLEN-1:0]    part;       // quotient or root
    logic [remWidth-1:0]     rem;
    logic [cntWidth-1:0]     cnt;

    logic                    isSqrt;
    logic [remWidth-1:0]     shifted;
    logic [remWidth-1:0]     subtr;
    logic [remWidth-1:0]     trial;
    logic                    stepOk;

    logic                    legalOp;
    logic                    needRun;
    logic [`DIV_SQN_W-1:0]   heldDiff;
    logic [`DIV_SQN_W-1:0]   newDiff;
    logic                    killHeld;
    logic                    killNew;

    // **************************************************
    // flush compare
    // **************************************************
    assign heldDiff = resSqN - flushSqN;
    assign newDiff  = sqN - flushSqN;
    assign killHeld = flushValid && ($signed(heldDiff) > 0);
    assign killNew  = flushValid && ($signed(newDiff) > 0);

    assign legalOp = op inside {divPkg::DIVU, divPkg::REMU, divPkg::SQRT};
    assign needRun = legalOp && ((op == divPkg::SQRT) || (srcB != '0));

    // **************************************************
    // restoring step, shared by divide and sqrt
    // **************************************************
    always_comb begin
        isSqrt = (opReg == divPkg::SQRT);
        if (isSqrt) begin
            shifted = {rem[remWidth-3:0], acc[`DIV_XLEN-1 -: 2]};
            subtr   = {part, 2'b01};
        end else begin
            shifted = {rem[remWidth-2:0], acc[`DIV_XLEN-1]};
            subtr   = remWidth'(divisor);
        end
        trial  = shifted - subtr;
        stepOk = !trial[remWidth-1];    // no borrow
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= divPkg::IDLE;
        end else begin
            case (state)
                divPkg::IDLE: begin
                    if (start && !killNew) begin
                        state <= needRun ? divPkg::RUN : divPkg::DONE;
                    end
                end
                divPkg::RUN: begin
                    if (killHeld) begin
                        state <= divPkg::IDLE;
                    end else if (cnt == '0) begin
                        state <= divPkg::DONE;
                    end
                end
                divPkg::DONE: begin
                    if (killHeld || taken) begin
                        state <= divPkg::IDLE;
                    end
                end
                default: state <= divPkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == divPkg::IDLE && start) begin
            opReg   <= op;
            resSqN  <= sqN;
            divisor <= srcB;
            acc     <= srcA;
            rem     <= '0;
            part    <= '0;
            flags   <= divPkg::NONE;
            if (op == divPkg::SQRT) begin
                cnt <= cntWidth'(`DIV_XLEN / 2 - 1);
            end else begin
                cnt <= cntWidth'(`DIV_XLEN - 1);
            end
            if (!legalOp) begin
                flags <= divPkg::ILLEGAL;
            end else if (op != divPkg::SQRT && srcB == '0) begin
                // all-ones quotient, dividend as remainder
                flags <= divPkg::DIV_ZERO;
                part  <= '1;
                rem   <= remWidth'(srcA);
            end
        end else if (state == divPkg::RUN) begin
            if (isSqrt) begin
                acc <= {acc[`DIV_XLEN-3:0], 2'b00};
            end else begin
                acc <= {acc[`DIV_XLEN-2:0], 1'b0};
            end
            part <= {part[`DIV_XLEN-2:0], stepOk};
            rem  <= stepOk ? trial : shifted;
            cnt  <= cnt - 1'b1;
        end
    end

    assign idle   = (state == divPkg::IDLE);
    assign done   = (state == divPkg::DONE) && !killHeld;  // flushed ops never report
    assign result = (opReg == divPkg::REMU) ? rem[`DIV_XLEN-1:0] : part;

endmodule

// File: design/divWriteback.sv
`timescale 1ns/1ps
`include "divCluster_defines.svh"

module divWriteback (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic [`DIV_UNITS-1:0]                    done,
    input  logic [`DIV_UNITS-1:0][`DIV_XLEN-1:0]     result,
    input  divPkg::divFlags_t [`DIV_UNITS-1:0]       flags,
    input  logic [`DIV_UNITS-1:0][`DIV_SQN_W-1:0]    unitSqN,
    output logic [`DIV_UNITS-1:0]                    taken,

    input  logic                                     wbAvail,
    output logic                                     resValid,
    output logic [`DIV_XLEN-1:0]                     resData,
    output divPkg::divFlags_t                        resFlags,
    output logic [`DIV_SQN_W-1:0]                    resSqN
);

    logic                     canLoad;
    logic [`DIV_UNITS-1:0]    pick;
    logic [`DIV_XLEN-1:0]     selData;
    divPkg::divFlags_t        selFlags;
    logic [`DIV_SQN_W-1:0]    selSqN;

    // output register empty or leaving this cycle
    assign canLoad = !resValid || wbAvail;
    assign pick    = done & (~done + 1'b1);   // fixed priority, unit 0 first
    assign taken   = canLoad ? pick : '0;

    always_comb begin
        selData  = '0;
        selFlags = divPkg::NONE;
        selSqN   = '0;
        for (int i = 0; i < `DIV_UNITS; i++) begin
            if (pick[i]) begin
                selData  = result[i];
                selFlags = flags[i];
                selSqN   = unitSqN[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else if (canLoad) begin
            resValid <= |done;
        end
    end

    always_ff @(posedge clk) begin
        if (canLoad && |done) begin
            resData  <= selData;
            resFlags <= selFlags;
            resSqN   <= selSqN;
        end
    end

endmodule

// File: design/divCluster.sv
`timescale 1ns/1ps
`include "divCluster_defines.svh"

module divCluster (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  divPkg::divOp_t           datOp,
    input  logic [`DIV_XLEN-1:0]     datA,
    input  logic [`DIV_XLEN-1:0]     datB,
    input  logic [`DIV_SQN_W-1:0]    datSqN,
    output logic                     ack,

    input  logic                     flushValid,
    input  logic [`DIV_SQN_W-1:0]    flushSqN,

    input  logic                     wbAvail,
    output logic                     resValid,
    output logic [`DIV_XLEN-1:0]     resData,
    output divPkg::divFlags_t        resFlags,
    output logic [`DIV_SQN_W-1:0]    resSqN
);

    // issue side
    logic [`DIV_UNITS-1:0]                    start;
    logic [`DIV_UNITS-1:0]                    idle;
    divPkg::divOp_t                           op;
    logic [`DIV_XLEN-1:0]                     srcA;
    logic [`DIV_XLEN-1:0]                     srcB;
    logic [`DIV_SQN_W-1:0]                    sqN;

    // writeback side
    logic [`DIV_UNITS-1:0]                    done;
    logic [`DIV_UNITS-1:0]                    taken;
    logic [`DIV_UNITS-1:0][`DIV_XLEN-1:0]     unitResult;
    divPkg::divFlags_t [`DIV_UNITS-1:0]       unitFlags;
    logic [`DIV_UNITS-1:0][`DIV_SQN_W-1:0]    unitSqN;

    divIssue i_issue (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .datOp      (datOp),
        .datA       (datA),
        .datB       (datB),
        .datSqN     (datSqN),
        .ack        (ack),
        .flushValid (flushValid),
        .flushSqN   (flushSqN),
        .idle       (idle),
        .start      (start),
        .op         (op),
        .srcA       (srcA),
        .srcB       (srcB),
        .sqN        (sqN)
    );

    for (genvar g = 0; g < `DIV_UNITS; g++) begin : g_unit
        divSqrtUnit i_unit (
            .clk        (clk),
            .rst        (rst),
            .start      (start[g]),
            .op         (op),
            .srcA       (srcA),
            .srcB       (srcB),
            .sqN        (sqN),
            .flushValid (flushValid),
            .flushSqN   (flushSqN),
            .taken      (taken[g]),
            .idle       (idle[g]),
            .done       (done[g]),
            .result     (unitResult[g]),
            .flags      (unitFlags[g]),
            .resSqN     (unitSqN[g])
        );
    end

    divWriteback i_writeback (
        .clk      (clk),
        .rst      (rst),
        .done     (done),
        .result   (unitResult),
        .flags    (unitFlags),
        .unitSqN  (unitSqN),
        .taken    (taken),
        .wbAvail  (wbAvail),
        .resValid (resValid),
        .resData  (resData),
        .resFlags (resFlags),
        .resSqN   (resSqN)
    );

endmodule

// File: dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;    // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: dv/divCluster_asserts.sv
`timescale 1ns/1ps
`include "divCluster_defines.svh"

module divCluster_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic                     stb,
    input logic                     ack,
    input logic                     wbAvail,
    input logic                     resValid,
    input logic [`DIV_XLEN-1:0]     resData,
    input divPkg::divFlags_t        resFlags,
    input logic [`DIV_SQN_W-1:0]    resSqN
);

    int failCount = 0;    // read by the testbench at the end

    ackNeedsStb: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(stb))
        else begin
            failCount++;
            $error("ack rose without a strobe in the cycle before");
        end

    // writeback holds until accepted
    resultHeld: assert property (@(posedge clk) disable iff (rst)
        resValid && !wbAvail |=> resValid && $stable(resData) && $stable(resFlags)
            && $stable(resSqN))
        else begin
            failCount++;
            $error("writeback result changed or dropped before it was accepted");
        end

    resetQuiet: assert property (@(posedge clk) rst |=> !resValid)
        else begin
            failCount++;
            $error("resValid high while in reset");
        end

endmodule

// File: dv/divClusterTb.sv
`timescale 1ns/1ps
`include "divCluster_defines.svh"

module divClusterTb;

    localparam int numOps    = 300;
    localparam int maxCycles = 40 * numOps + 1000;
    localparam int sqMod     = 1 << `DIV_SQN_W;

    logic                    clk;
    logic                    rst;
    logic                    cyc;
    logic                    stb;
    logic                    we;
    divPkg::divOp_t          datOp;
    logic [`DIV_XLEN-1:0]    datA;
    logic [`DIV_XLEN-1:0]    datB;
    logic [`DIV_SQN_W-1:0]   datSqN;
    logic                    ack;
    logic                    flushValid;
    logic [`DIV_SQN_W-1:0]   flushSqN;
    logic                    wbAvail;
    logic                    resValid;
    logic [`DIV_XLEN-1:0]    resData;
    divPkg::divFlags_t       resFlags;
    logic [`DIV_SQN_W-1:0]   resSqN;

    // scoreboard keyed by sequence number
    logic [`DIV_XLEN-1:0]    expData [int];
    divPkg::divFlags_t       expFlags [int];
    bit                      returned [sqMod];

    int  valueErrors = 0;
    int  otherErrors = 0;
    int  cycles      = 0;
    int  issued      = 0;
    int  delivered   = 0;
    int  flushed     = 0;
    int  nextSq      = 0;
    int  wbCount     = 0;
    bit  holding     = 0;

    tbClock i_clock (
        .clk (clk),
        .rst (rst)
    );

    divCluster i_dut (
        .clk        (clk),
        .rst        (rst),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .datOp      (datOp),
        .datA       (datA),
        .datB       (datB),
        .datSqN     (datSqN),
        .ack        (ack),
        .flushValid (flushValid),
        .flushSqN   (flushSqN),
        .wbAvail    (wbAvail),
        .resValid   (resValid),
        .resData    (resData),
        .resFlags   (resFlags),
        .resSqN     (resSqN)
    );

    bind divCluster divCluster_asserts i_asserts (
        .clk      (clk),
        .rst      (rst),
        .stb      (stb),
        .ack      (ack),
        .wbAvail  (wbAvail),
        .resValid (resValid),
        .resData  (resData),
        .resFlags (resFlags),
        .resSqN   (resSqN)
    );

    // **************************************************
    // reference model
    // **************************************************
    function automatic bit isYounger(input int sq, input int fl);
        int d;
        d = (sq - fl) & (sqMod - 1);
        return (d != 0) && (d < sqMod / 2);    // signed difference above zero
    endfunction

    function automatic logic [`DIV_XLEN-1:0] floorSqrt(input logic [`DIV_XLEN-1:0] x);
        longint lo;
        longint hi;
        longint mid;
        lo = 0;
        hi = 65535;
        while (lo < hi) begin
            mid = (lo + hi + 1) / 2;
            if (mid * mid <= longint'(x)) begin
                lo = mid;
            end else begin
                hi = mid - 1;
            end
        end
        return lo[`DIV_XLEN-1:0];
    endfunction

    function automatic logic [`DIV_XLEN-1:0] modelData(input divPkg::divOp_t o,
                                                       input logic [`DIV_XLEN-1:0] a,
                                                       input logic [`DIV_XLEN-1:0] b);
        case (o)
            divPkg::DIVU: return (b == 0) ? {`DIV_XLEN{1'b1}} : a / b;
            divPkg::REMU: return (b == 0) ? a : a % b;
            divPkg::SQRT: return floorSqrt(a);
            default:      return '0;
        endcase
    endfunction

    function automatic divPkg::divFlags_t modelFlags(input divPkg::divOp_t o,
                                                     input logic [`DIV_XLEN-1:0] b);
        if (!(o inside {divPkg::DIVU, divPkg::REMU, divPkg::SQRT})) begin
            return divPkg::ILLEGAL;
        end
        if (o != divPkg::SQRT && b == 0) begin
            return divPkg::DIV_ZERO;
        end
        return divPkg::NONE;
    endfunction

    // **************************************************
    // compare tasks
    // **************************************************
    task automatic checkData(input int sq, input logic [`DIV_XLEN-1:0] got,
                             input logic [`DIV_XLEN-1:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("FAILED at %0t: seq %0d result %h, expected %h", $time, sq, got, exp);
        end
    endtask

    task automatic checkFlags(input int sq, input divPkg::divFlags_t got,
                              input divPkg::divFlags_t exp);
        if (got !== exp) begin
            valueErrors++;
            $display("FAILED at %0t: seq %0d flags %0d, expected %0d", $time, sq, got, exp);
        end
    endtask

    task automatic recordOp(input int sq);
        if (expData.exists(sq)) begin
            otherErrors++;
            $display("sequence number %0d reused while its result is still outstanding", sq);
        end
        expData[sq]  = modelData(datOp, datA, datB);
        expFlags[sq] = modelFlags(datOp, datB);
        returned[sq] = 1'b0;
    endtask

    task automatic applyFlush(input int fl);
        int victims[$];
        foreach (expData[k]) begin
            // a result already in the output register counts as delivered
            if (isYounger(k, fl) && !(resValid && resSqN == k)) begin
                victims.push_back(k);
            end
        end
        foreach (victims[i]) begin
            expData.delete(victims[i]);
            expFlags.delete(victims[i]);
            flushed++;
        end
    endtask

    task automatic takeResult();
        int sq;
        sq = int'(resSqN);
        if (expData.exists(sq)) begin
            checkData(sq, resData, expData[sq]);
            checkFlags(sq, resFlags, expFlags[sq]);
            expData.delete(sq);
            expFlags.delete(sq);
            returned[sq] = 1'b1;
            delivered++;
        end else if (returned[sq]) begin
            otherErrors++;
            $display("result for sequence number %0d was returned a second time", sq);
        end else begin
            otherErrors++;
            $display("result came back with unknown sequence number %0d", sq);
        end
    endtask

    task automatic presentOp();
        int pick;
        pick = $urandom_range(99);
        if (pick < 35) begin
            datOp = divPkg::DIVU;
        end else if (pick < 65) begin
            datOp = divPkg::REMU;
        end else if (pick < 90) begin
            datOp = divPkg::SQRT;
        end else begin
            datOp = divPkg::divOp_t'(3'($urandom_range(7, 3)));
        end
        datA = $urandom();
        datB = ($urandom_range(9) == 0) ? '0 : $urandom() >> $urandom_range(31);
        if (datOp == divPkg::SQRT && $urandom_range(3) == 0) begin
            case ($urandom_range(2))
                0:       datA = '0;
                1:       datA = 1;
                default: datA = '1;
            endcase
        end
        datSqN = nextSq[`DIV_SQN_W-1:0];
        nextSq = (nextSq + 1) % sqMod;
        cyc     = 1'b1;
        stb     = 1'b1;
        we      = 1'b1;
        holding = 1'b1;
        issued++;
    endtask

    // **************************************************
    // one clock of stimulus and checking
    // **************************************************
    task automatic stepCycle(input bit stimulate);
        @(posedge clk);
        #1;
        // accepted on this edge, under the flush that was on the bus
        if (ack && holding) begin
            holding = 1'b0;
            if (flushValid && isYounger(datSqN, flushSqN)) begin
                flushed++;
            end else begin
                recordOp(datSqN);
            end
        end
        flushValid = 1'b0;
        if (stimulate && $urandom_range(39) == 0) begin
            flushValid = 1'b1;
            flushSqN   = `DIV_SQN_W'(nextSq - 1 - $urandom_range(5));
            applyFlush(flushSqN);
        end
        if (!stimulate) begin
            wbAvail = 1'b1;
        end else if (wbCount == 0) begin
            wbAvail = !wbAvail;
            wbCount = wbAvail ? $urandom_range(30, 1) : $urandom_range(60, 1);
        end else begin
            wbCount--;
        end
        if (!holding) begin
            if (stimulate && issued < numOps && $urandom_range(3) != 0) begin
                presentOp();
            end else begin
                cyc = 1'b0;
                stb = 1'b0;
            end
        end
        if (resValid && wbAvail) begin
            takeResult();
        end
    endtask

    task automatic closeRun();
        int total;
        total = valueErrors + otherErrors + i_dut.i_asserts.failCount;
        $display("errors: %0d value, %0d other, %0d assertion (%0d issued, %0d returned, %0d flushed)",
                 valueErrors, otherErrors, i_dut.i_asserts.failCount, issued, delivered, flushed);
        if (total == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(87650));
        $timeformat(-9, 0, " ns", 0);
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        datOp      = divPkg::DIVU;
        datA       = '0;
        datB       = '0;
        datSqN     = '0;
        flushValid = 1'b0;
        flushSqN   = '0;
        wbAvail    = 1'b1;
        @(negedge rst);
        while (issued < numOps || holding || expData.num() > 0) begin
            stepCycle(1'b1);
        end
        repeat (100) stepCycle(1'b0);    // catch late or flushed results
        closeRun();
    end

    // timeout
    initial begin
        while (cycles < maxCycles) begin
            @(posedge clk);
            cycles++;
        end
        otherErrors++;
        $display("timeout after %0d cycles with %0d results still outstanding",
                 cycles, expData.num());
        closeRun();
    end

endmodule

// File: flist.f
+incdir+design
design/divPkg.sv
design/divIssue.sv
design/divSqrtUnit.sv
design/divWriteback.sv
design/divCluster.sv
dv/tbClock.sv
dv/divCluster_asserts.sv
dv/divClusterTb.sv

// File: Bender.yml
package:
  name: div_cluster

sources:
  - include_dirs:
      - design
    files:
      - design/divPkg.sv
      - design/divIssue.sv
      - design/divSqrtUnit.sv
      - design/divWriteback.sv
      - design/divCluster.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - dv/tbClock.sv
      - dv/divCluster_asserts.sv
      - dv/divClusterTb.sv
